//--- build.f
design/stream_types_pkg.sv
design/read_cmd_pkg.sv
design/mixed_width_ram.sv
design/stream_config_regs.sv
design/cacheline_fetch.sv
design/cacheline_stream.sv
design/array_stream_top.sv
verif/tb_mem_model.sv
verif/tb_array_stream.sv

//--- design/array_stream_top.sv
// Array streaming subsystem. Memory sits outside and must answer each
// command with both halves; response ports have no back-pressure
`timescale 1ns/1ps
`default_nettype none

module array_stream_top #(
	parameter int ELEM_BITS = 16
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      reg_wr_valid,
	input  logic [2:0]                reg_addr,
	input  logic [15:0]               reg_wr_data,
	input  logic                      cmd_ready,
	input  read_cmd_pkg::read_resp_t  resp_0,
	input  read_cmd_pkg::read_resp_t  resp_1,
	input  logic                      elem_ready,
	output logic [15:0]               reg_rd_data,
	output read_cmd_pkg::read_cmd_t   cmd,
	output logic                      cmd_valid,
	output logic [ELEM_BITS-1:0]      elem,
	output logic                      elem_valid
);

	read_cmd_pkg::stream_cfg_t run_cfg;
	logic                      run_busy;
	logic                      line_pending;

	stream_config_regs regs (
		.clock       (clock),
		.rstn        (rstn),
		.reg_wr_valid(reg_wr_valid),
		.reg_addr    (reg_addr),
		.reg_wr_data (reg_wr_data),
		.run_busy    (run_busy),
		.reg_rd_data (reg_rd_data),
		.run_cfg     (run_cfg)
	);

	cacheline_fetch #(
		.ELEM_BITS(ELEM_BITS)
	) fetch (
		.clock       (clock),
		.rstn        (rstn),
		.run_cfg     (run_cfg),
		.cmd_ready   (cmd_ready),
		.line_pending(line_pending),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.run_busy    (run_busy)
	);

	cacheline_stream #(
		.ELEM_BITS(ELEM_BITS)
	) unpack (
		.clock       (clock),
		.rstn        (rstn),
		.array_tag   (run_cfg.tag),
		.resp_0      (resp_0),
		.resp_1      (resp_1),
		.elem_ready  (elem_ready),
		.elem        (elem),
		.elem_valid  (elem_valid),
		.line_pending(line_pending)
	);

endmodule

`default_nettype wire

//--- design/cacheline_fetch.sv
// Turns an element range into one read command per cache line touched.
// Only one line is in flight; the next command waits for line_pending to drop
`timescale 1ns/1ps
`default_nettype none

module cacheline_fetch #(
	parameter int ELEM_BITS = 16
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  read_cmd_pkg::stream_cfg_t  run_cfg,
	input  logic                       cmd_ready,
	input  logic                       line_pending,
	output read_cmd_pkg::read_cmd_t    cmd,
	output logic                       cmd_valid,
	output logic                       run_busy
);

	localparam int            IB  = stream_types_pkg::INDEX_BITS;
	localparam logic [IB-1:0] EPL = IB'(stream_types_pkg::LINE_BITS / ELEM_BITS);

	typedef enum logic [1:0] {
		F_IDLE,
		F_ISSUE,
		F_WAIT_LINE,
		F_DRAIN
	} fetch_state_t;

	fetch_state_t  state;
	logic [IB-1:0] next_index;
	logic [IB-1:0] remaining;
	logic [IB-1:0] offset_full;
	logic [IB-1:0] line_room;
	logic [IB-1:0] used_full;

	// ------------------------------------------------------------
	// Per-line split of the range
	// ------------------------------------------------------------
	assign offset_full = next_index % EPL;
	assign line_room   = EPL - offset_full;
	assign used_full   = (remaining < line_room) ? remaining : line_room;

	assign cmd = '{
		tag:       run_cfg.tag,
		line_addr: next_index / EPL,
		offset:    offset_full[7:0],
		used:      used_full[7:0]
	};

	assign cmd_valid = (state == F_ISSUE);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= F_IDLE;
			next_index <= '0;
			remaining  <= '0;
			run_busy   <= 1'b0;
		end else begin
			case (state)
				F_IDLE: begin
					if (run_cfg.start) begin
						next_index <= run_cfg.base;
						remaining  <= run_cfg.count;
						run_busy   <= 1'b1;
						// Empty range goes straight to completion
						state      <= (run_cfg.count != '0) ? F_ISSUE : F_DRAIN;
					end
				end
				F_ISSUE: begin
					if (cmd_ready) begin
						next_index <= next_index + used_full;
						remaining  <= remaining - used_full;
						state      <= F_WAIT_LINE;
					end
				end
				// Wait for the first half to land
				F_WAIT_LINE: begin
					if (line_pending) begin
						state <= F_DRAIN;
					end
				end
				F_DRAIN: begin
					if (!line_pending) begin
						if (remaining == '0) begin
							run_busy <= 1'b0;
							state    <= F_IDLE;
						end else begin
							state <= F_ISSUE;
						end
					end
				end
				default: state <= F_IDLE;
			endcase
		end
	end

	a_cmd_stable: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));

	a_used_nonzero: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> cmd.used != 8'd0);

endmodule

`default_nettype wire

//--- design/cacheline_stream.sv
// Collects the two tagged halves of one line and streams its used elements.
// Responses with another tag are dropped; there is no back-pressure on them
`timescale 1ns/1ps
`default_nettype none

module cacheline_stream #(
	parameter int ELEM_BITS = 16
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  stream_types_pkg::array_id_t  array_tag,
	input  read_cmd_pkg::read_resp_t     resp_0,
	input  read_cmd_pkg::read_resp_t     resp_1,
	input  logic                         elem_ready,
	output logic [ELEM_BITS-1:0]         elem,
	output logic                         elem_valid,
	output logic                         line_pending
);

	localparam int EPL     = stream_types_pkg::LINE_BITS / ELEM_BITS;
	localparam int RD_BITS = $clog2(EPL);

	read_cmd_pkg::read_resp_t resp_q;
	read_cmd_pkg::read_resp_t hold_q;
	logic                     part_q;
	logic                     match_0;
	logic                     match_1;
	logic                     pending_q;
	logic                     half_seen;
	logic [RD_BITS-1:0]       rd_ptr;
	logic [7:0]               left_q;
	logic                     take;
	logic                     last_take;

	assign match_0 = resp_0.valid && (resp_0.cmd.tag == array_tag) &&
		(array_tag != stream_types_pkg::ARRAY_NONE);
	assign match_1 = resp_1.valid && (resp_1.cmd.tag == array_tag) &&
		(array_tag != stream_types_pkg::ARRAY_NONE);

	// ------------------------------------------------------------
	// Response capture, port 0 first
	// ------------------------------------------------------------
	// A high half arriving with the low half waits one cycle in hold_q
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_q <= '0;
			hold_q <= '0;
			part_q <= 1'b0;
		end else begin
			if (match_0) begin
				resp_q <= resp_0;
				part_q <= 1'b0;
			end else if (hold_q.valid) begin
				resp_q <= hold_q;
				part_q <= 1'b1;
			end else if (match_1) begin
				resp_q <= resp_1;
				part_q <= 1'b1;
			end else begin
				resp_q.valid <= 1'b0;
			end

			if (match_0 && match_1) begin
				hold_q <= resp_1;
			end else begin
				hold_q.valid <= 1'b0;
			end
		end
	end

	assign take      = elem_valid && elem_ready;
	assign last_take = take && (left_q == 8'd1);

	// Drops together with the last accepted element
	assign line_pending = pending_q && !last_take;

	// ------------------------------------------------------------
	// Line tracking and element shift-out
	// ------------------------------------------------------------
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pending_q  <= 1'b0;
			half_seen  <= 1'b0;
			elem_valid <= 1'b0;
			rd_ptr     <= '0;
			left_q     <= '0;
		end else begin
			if (match_0 || match_1) begin
				pending_q <= 1'b1;
			end else if (last_take) begin
				pending_q <= 1'b0;
			end

			if (resp_q.valid) begin
				if (!half_seen) begin
					half_seen <= 1'b1;
				end else begin
					// Second half written this edge, line complete
					half_seen  <= 1'b0;
					rd_ptr     <= resp_q.cmd.offset[RD_BITS-1:0];
					left_q     <= resp_q.cmd.used;
					elem_valid <= (resp_q.cmd.used != 8'd0);
				end
			end

			if (take) begin
				left_q <= left_q - 8'd1;
				if (left_q == 8'd1) begin
					elem_valid <= 1'b0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
		end
	end

	mixed_width_ram #(
		.ELEM_BITS(ELEM_BITS)
	) line_store (
		.clock   (clock),
		.we      (resp_q.valid),
		.wr_addr (part_q),
		.data_in (resp_q.data),
		.rd_addr (rd_ptr),
		.data_out(elem)
	);

	a_elem_stable: assert property (@(posedge clock) disable iff (!rstn)
		elem_valid && !elem_ready |=> elem_valid && $stable(elem));

endmodule

`default_nettype wire

//--- design/mixed_width_ram.sv
// Two half-line words, written whole and read one element at a time.
// ELEM_BITS must divide HALF_BITS
`timescale 1ns/1ps
`default_nettype none

module mixed_width_ram #(
	parameter int ELEM_BITS = 16
) (
	input  logic                                                    clock,
	input  logic                                                    we,
	input  logic                                                    wr_addr,
	input  logic [stream_types_pkg::HALF_BITS-1:0]                  data_in,
	input  logic [$clog2(stream_types_pkg::LINE_BITS/ELEM_BITS)-1:0] rd_addr,
	output logic [ELEM_BITS-1:0]                                    data_out
);

	localparam int HB = stream_types_pkg::HALF_BITS;

	logic [HB-1:0]   mem [0:1];
	logic [2*HB-1:0] line;

	always_ff @(posedge clock) begin
		if (we) begin
			mem[wr_addr] <= data_in;
		end
	end

	// Element 0 sits in the low bits of word 0
	assign line     = {mem[1], mem[0]};
	assign data_out = line[rd_addr*ELEM_BITS +: ELEM_BITS];

endmodule

`default_nettype wire

//--- design/read_cmd_pkg.sv
// Command, response and run configuration records
// Offset and used count fields are 8 bits, enough for 8-bit elements
`default_nettype none

package read_cmd_pkg;

	// One cache-line read, echoed back on both response halves
	typedef struct packed {
		stream_types_pkg::array_id_t                    tag;
		logic [stream_types_pkg::INDEX_BITS-1:0]        line_addr;
		logic [7:0]                                     offset;
		logic [7:0]                                     used;
	} read_cmd_t;

	// Half-line response
	// Port 0 carries the low half, port 1 the high half
	typedef struct packed {
		logic                                           valid;
		read_cmd_t                                      cmd;
		logic [stream_types_pkg::HALF_BITS-1:0]         data;
	} read_resp_t;

	// Run configuration from the register block
	typedef struct packed {
		stream_types_pkg::array_id_t                    tag;
		logic [stream_types_pkg::INDEX_BITS-1:0]        base;
		logic [stream_types_pkg::INDEX_BITS-1:0]        count;
		logic                                           start;
	} stream_cfg_t;

endpackage

`default_nettype wire

//--- design/stream_config_regs.sv
// Host registers for one streaming run. Writes to tag, base, count and
// control are ignored while a run is busy
`timescale 1ns/1ps
`default_nettype none

module stream_config_regs (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       reg_wr_valid,
	input  logic [2:0]                 reg_addr,
	input  logic [15:0]                reg_wr_data,
	input  logic                       run_busy,
	output logic [15:0]                reg_rd_data,
	output read_cmd_pkg::stream_cfg_t  run_cfg
);

	localparam int IB = stream_types_pkg::INDEX_BITS;

	stream_types_pkg::array_id_t tag_q;
	logic [IB-1:0]               base_q;
	logic [IB-1:0]               count_q;
	logic                        start_q;
	logic                        busy_q;
	logic                        done_q;
	logic                        locked;

	// Busy as seen by the host, covering the start cycle too
	assign locked = run_busy | start_q;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			tag_q   <= stream_types_pkg::ARRAY_NONE;
			base_q  <= '0;
			count_q <= '0;
			start_q <= 1'b0;
			busy_q  <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			start_q <= 1'b0;
			busy_q  <= run_busy;

			// Falling edge of run_busy marks completion
			if (busy_q && !run_busy) begin
				done_q <= 1'b1;
			end

			if (reg_wr_valid && !locked) begin
				case (reg_addr)
					3'd0: tag_q   <= stream_types_pkg::array_id_t'(reg_wr_data[1:0]);
					3'd1: base_q  <= reg_wr_data;
					3'd2: count_q <= reg_wr_data;
					3'd3: begin
						if (reg_wr_data[0]) begin
							start_q <= 1'b1;
							done_q  <= 1'b0;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// ------------------------------------------------------------
	// Read mux, no handshake
	// ------------------------------------------------------------
	always_comb begin
		case (reg_addr)
			3'd0:    reg_rd_data = 16'(tag_q);
			3'd1:    reg_rd_data = base_q;
			3'd2:    reg_rd_data = count_q;
			3'd4:    reg_rd_data = {14'd0, done_q, locked};
			default: reg_rd_data = 16'd0;
		endcase
	end

	assign run_cfg = '{tag: tag_q, base: base_q, count: count_q, start: start_q};

	// The fetch engine only raises busy in answer to a start
	a_start_not_busy: assert property (@(posedge clock) disable iff (!rstn)
		start_q |-> !run_busy);

endmodule

`default_nettype wire

//--- design/stream_types_pkg.sv
// Line geometry shared by every block. ELEM_BITS itself is a module parameter
// and must divide HALF_BITS (8, 16, 32 or 64)
`default_nettype none

package stream_types_pkg;

	// ------------------------------------------------------------
	// Line geometry
	// ------------------------------------------------------------
	localparam int LINE_BITS  = 128;
	localparam int HALF_BITS  = LINE_BITS / 2;
	localparam int INDEX_BITS = 16;

	// ------------------------------------------------------------
	// Array tags
	// ------------------------------------------------------------
	// ARRAY_NONE is the idle value and is never accepted on a response
	typedef enum logic [1:0] {
		ARRAY_NONE   = 2'd0,
		ARRAY_VERTEX = 2'd1,
		ARRAY_EDGE   = 2'd2,
		ARRAY_WEIGHT = 2'd3
	} array_id_t;

endpackage

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the array streaming testbench with Verilator and runs it.
# The run counts as failed when the log holds the fail message.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f build.f \
	--top-module tb_array_stream \
	-o tb_array_stream

./obj_dir/tb_array_stream | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

echo "Simulation finished, log in sim.log"

//--- verif/tb_array_stream.sv
// Directed tests for the array streaming subsystem with 16-bit elements.
// Ready signals and memory timing come from one Galois LFSR
`timescale 1ns/1ps
`default_nettype none

module tb_array_stream;

	localparam int ELEM_BITS       = 16;
	localparam int EPL             = stream_types_pkg::LINE_BITS / ELEM_BITS;
	localparam int TOTAL_ELEMS     = 16 + 11 + 40 + 24 + 9 + 13;
	localparam int WATCHDOG_CYCLES = 200 * TOTAL_ELEMS + 1000;

	logic                      clock;
	logic                      rstn;
	logic                      reg_wr_valid;
	logic [2:0]                reg_addr;
	logic [15:0]               reg_wr_data;
	logic                      cmd_ready;
	read_cmd_pkg::read_resp_t  resp_0;
	read_cmd_pkg::read_resp_t  resp_1;
	logic                      elem_ready;
	logic [15:0]               reg_rd_data;
	read_cmd_pkg::read_cmd_t   cmd;
	logic                      cmd_valid;
	logic [ELEM_BITS-1:0]      elem;
	logic                      elem_valid;

	logic [31:0]               lfsr_state;
	logic [6:0]                model_rnd;
	logic                      inject_en;
	logic                      random_ready;
	logic [ELEM_BITS-1:0]      got_q[$];
	read_cmd_pkg::read_cmd_t   cmd_q[$];
	int                        error_count;
	int                        test_count;
	int                        failed_tests;

	array_stream_top #(
		.ELEM_BITS(ELEM_BITS)
	) dut (
		.clock       (clock),
		.rstn        (rstn),
		.reg_wr_valid(reg_wr_valid),
		.reg_addr    (reg_addr),
		.reg_wr_data (reg_wr_data),
		.cmd_ready   (cmd_ready),
		.resp_0      (resp_0),
		.resp_1      (resp_1),
		.elem_ready  (elem_ready),
		.reg_rd_data (reg_rd_data),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.elem        (elem),
		.elem_valid  (elem_valid)
	);

	tb_mem_model #(
		.ELEM_BITS(ELEM_BITS)
	) mem (
		.clock    (clock),
		.rstn     (rstn),
		.cmd      (cmd),
		.cmd_valid(cmd_valid),
		.rnd      (model_rnd),
		.inject_en(inject_en),
		.cmd_ready(cmd_ready),
		.resp_0   (resp_0),
		.resp_1   (resp_1)
	);

	always #5 clock = ~clock;

	// ------------------------------------------------------------
	// Random source
	// ------------------------------------------------------------
	function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic draw_bits(input int n, output logic [7:0] bits);
		int k;
		bits = '0;
		for (k = 0; k < n; k++) begin
			bits[k]    = lfsr_state[0];
			lfsr_state = lfsr_advance(lfsr_state);
		end
	endtask

	// Eight bits per cycle: memory timing, injection, cmd_ready, elem_ready
	always @(posedge clock) begin : random_draw
		logic [7:0] bits;
		draw_bits(8, bits);
		model_rnd  <= bits[6:0];
		elem_ready <= random_ready ? bits[7] : 1'b1;
	end

	// Element and command taken at the coming edge
	always @(negedge clock) begin
		if (rstn && elem_valid && elem_ready) begin
			got_q.push_back(elem);
		end
		if (rstn && cmd_valid && cmd_ready) begin
			cmd_q.push_back(cmd);
		end
	end

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	function automatic logic [ELEM_BITS-1:0] expected_elem(
		input stream_types_pkg::array_id_t tag, input int index);
		longint unsigned v;
		v = 64'(tag) * 64'd4096 + 64'(index);
		return v[ELEM_BITS-1:0];
	endfunction

	task automatic value_error(input string test, input string what,
		input longint unsigned expected, input longint unsigned actual);
		$display("** Error %s: %s expected 0x%0h, actual 0x%0h", test, what, expected, actual);
		error_count++;
	endtask

	task automatic end_test(input string test, input int errs_before);
		test_count++;
		if (error_count == errs_before) begin
			$display("test %s: ok", test);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", test, error_count - errs_before);
		end
	endtask

	task automatic write_reg(input logic [2:0] addr, input logic [15:0] data);
		@(posedge clock);
		reg_wr_valid <= 1'b1;
		reg_addr     <= addr;
		reg_wr_data  <= data;
		@(posedge clock);
		reg_wr_valid <= 1'b0;
	endtask

	task automatic read_reg(input logic [2:0] addr, output logic [15:0] data);
		@(posedge clock);
		reg_addr <= addr;
		@(negedge clock);
		data = reg_rd_data;
	endtask

	task automatic start_run(input stream_types_pkg::array_id_t tag, input int base,
		input int count);
		got_q.delete();
		cmd_q.delete();
		write_reg(3'd0, 16'(tag));
		write_reg(3'd1, 16'(base));
		write_reg(3'd2, 16'(count));
		write_reg(3'd3, 16'h0001);
	endtask

	// One command per line touched, each covering the part of the range in its line
	task automatic check_commands(input string test, input stream_types_pkg::array_id_t tag,
		input int base, input int count);
		int first_line;
		int n_lines;
		int k;
		int line;
		int lo;
		int hi;
		first_line = base / EPL;
		n_lines    = (base + count - 1) / EPL - first_line + 1;
		if (cmd_q.size() != n_lines) begin
			value_error(test, "command count", 64'(n_lines), 64'(cmd_q.size()));
		end
		for (k = 0; k < n_lines && k < cmd_q.size(); k++) begin
			line = first_line + k;
			lo   = (base > line * EPL) ? base : line * EPL;
			hi   = (base + count < (line + 1) * EPL) ? base + count : (line + 1) * EPL;
			if (cmd_q[k].tag !== tag) begin
				value_error(test, $sformatf("command %0d tag", k),
					64'(tag), 64'(cmd_q[k].tag));
			end
			if (cmd_q[k].line_addr !== 16'(line)) begin
				value_error(test, $sformatf("command %0d line", k),
					64'(line), 64'(cmd_q[k].line_addr));
			end
			if (cmd_q[k].offset !== 8'(lo - line * EPL)) begin
				value_error(test, $sformatf("command %0d offset", k),
					64'(lo - line * EPL), 64'(cmd_q[k].offset));
			end
			if (cmd_q[k].used !== 8'(hi - lo)) begin
				value_error(test, $sformatf("command %0d used", k),
					64'(hi - lo), 64'(cmd_q[k].used));
			end
		end
	endtask

	// Waits for done, then compares every collected element with the content rule
	task automatic finish_run(input string test, input stream_types_pkg::array_id_t tag,
		input int base, input int count);
		bit finished;
		int n;
		int limit;
		int n_check;
		int i;
		limit    = 200 * count + 1000;
		finished = 1'b0;
		n        = 0;
		@(posedge clock);
		reg_addr <= 3'd4;
		while (!finished && n < limit) begin
			@(negedge clock);
			if (reg_rd_data[1]) begin
				finished = 1'b1;
			end
			n++;
		end
		if (!finished) begin
			$display("Error in %s: done never came within %0d cycles", test, limit);
			error_count++;
		end
		// A few more cycles so that stray elements show up
		repeat (4) @(negedge clock);
		if (got_q.size() != count) begin
			value_error(test, "element count", 64'(count), 64'(got_q.size()));
		end
		n_check = (got_q.size() < count) ? got_q.size() : count;
		for (i = 0; i < n_check; i++) begin
			if (got_q[i] !== expected_elem(tag, base + i)) begin
				value_error(test, $sformatf("element %0d", base + i),
					64'(expected_elem(tag, base + i)), 64'(got_q[i]));
			end
		end
		check_commands(test, tag, base, count);
		if (elem_valid !== 1'b0) begin
			value_error(test, "elem_valid after run", 64'd0, 64'(elem_valid));
		end
		if (reg_rd_data !== 16'h0002) begin
			value_error(test, "status after run", 64'h2, 64'(reg_rd_data));
		end
	endtask

	// ------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------
	task automatic test_after_reset();
		logic [15:0] value;
		int          errs_before;
		errs_before = error_count;
		@(negedge clock);
		if (elem_valid !== 1'b0) begin
			value_error("after_reset", "elem_valid", 64'd0, 64'(elem_valid));
		end
		if (cmd_valid !== 1'b0) begin
			value_error("after_reset", "cmd_valid", 64'd0, 64'(cmd_valid));
		end
		read_reg(3'd4, value);
		if (value !== 16'h0000) begin
			value_error("after_reset", "status", 64'd0, 64'(value));
		end
		read_reg(3'd0, value);
		if (value !== 16'h0000) begin
			value_error("after_reset", "tag register", 64'd0, 64'(value));
		end
		end_test("after_reset", errs_before);
	endtask

	task automatic test_run(input string test, input stream_types_pkg::array_id_t tag,
		input int base, input int count, input logic rand_ready, input logic inject);
		int errs_before;
		errs_before = error_count;
		@(negedge clock);
		random_ready = rand_ready;
		start_run(tag, base, count);
		// Foreign traffic starts once the run's tag is in place
		@(negedge clock);
		inject_en = inject;
		finish_run(test, tag, base, count);
		@(negedge clock);
		random_ready = 1'b0;
		inject_en    = 1'b0;
		end_test(test, errs_before);
	endtask

	task automatic test_restart();
		logic [15:0] value;
		int          errs_before;
		errs_before = error_count;
		start_run(stream_types_pkg::ARRAY_WEIGHT, 100, 9);
		finish_run("restart_first", stream_types_pkg::ARRAY_WEIGHT, 100, 9);
		start_run(stream_types_pkg::ARRAY_EDGE, 40, 13);
		// Busy set and done cleared by the new start
		read_reg(3'd4, value);
		if (value !== 16'h0001) begin
			value_error("restart", "status after start", 64'h1, 64'(value));
		end
		finish_run("restart", stream_types_pkg::ARRAY_EDGE, 40, 13);
		end_test("restart", errs_before);
	endtask

	initial begin
		clock        = 1'b0;
		rstn         = 1'b0;
		reg_wr_valid = 1'b0;
		reg_addr     = 3'd0;
		reg_wr_data  = 16'd0;
		elem_ready   = 1'b0;
		lfsr_state   = 32'h3c22;
		model_rnd    = '0;
		inject_en    = 1'b0;
		random_ready = 1'b0;
		error_count  = 0;
		test_count   = 0;
		failed_tests = 0;
		repeat (2) @(posedge clock);
		rstn <= 1'b1;

		test_after_reset();
		test_run("aligned_run", stream_types_pkg::ARRAY_VERTEX, 0, 16, 1'b0, 1'b0);
		test_run("unaligned_run", stream_types_pkg::ARRAY_EDGE, 3, 11, 1'b0, 1'b0);
		test_run("back_pressure", stream_types_pkg::ARRAY_WEIGHT, 20, 40, 1'b1, 1'b0);
		test_run("tag_filter", stream_types_pkg::ARRAY_VERTEX, 6, 24, 1'b0, 1'b1);
		test_restart();

		$display("tests run: %0d, tests failed: %0d, errors: %0d",
			test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Watchdog sized from the total element count
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Timeout: the tests did not end within %0d cycles", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/tb_mem_model.sv
// Memory responder for one line in flight; each half returns 3 to 6 cycles after
// its command. Element i of array t holds t*4096 + i, cut to ELEM_BITS
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
	parameter int ELEM_BITS = 16
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  read_cmd_pkg::read_cmd_t   cmd,
	input  logic                      cmd_valid,
	input  logic [6:0]                rnd,
	input  logic                      inject_en,
	output logic                      cmd_ready,
	output read_cmd_pkg::read_resp_t  resp_0,
	output read_cmd_pkg::read_resp_t  resp_1
);

	localparam int HB  = stream_types_pkg::HALF_BITS;
	localparam int EPL = stream_types_pkg::LINE_BITS / ELEM_BITS;
	localparam int EPH = EPL / 2;

	read_cmd_pkg::read_cmd_t cur;
	read_cmd_pkg::read_cmd_t foreign;
	logic                    pend_lo;
	logic                    pend_hi;
	logic [2:0]              cnt_lo;
	logic [2:0]              cnt_hi;
	logic                    lo_due;
	logic                    hi_due;

	// One half of a line filled from the content rule
	function automatic logic [HB-1:0] half_data(input read_cmd_pkg::read_cmd_t c,
		input logic high);
		logic [HB-1:0]   d;
		longint unsigned idx;
		longint unsigned val;
		int              j;
		d = '0;
		for (j = 0; j < EPH; j++) begin
			idx = 64'(c.line_addr) * 64'(EPL) + (high ? 64'(EPH) : 64'd0) + 64'(j);
			val = 64'(c.tag) * 64'd4096 + idx;
			d[j*ELEM_BITS +: ELEM_BITS] = val[ELEM_BITS-1:0];
		end
		return d;
	endfunction

	// Weight-tagged traffic that the DUT must drop
	assign foreign = '{
		tag:       stream_types_pkg::ARRAY_WEIGHT,
		line_addr: cur.line_addr,
		offset:    8'd0,
		used:      8'(EPL)
	};

	assign lo_due = pend_lo && (cnt_lo == 3'd1);
	assign hi_due = pend_hi && (cnt_hi == 3'd1);

	initial begin
		cmd_ready = 1'b0;
		resp_0    = '0;
		resp_1    = '0;
	end

	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_ready <= 1'b0;
			resp_0    <= '0;
			resp_1    <= '0;
			cur       <= '0;
			pend_lo   <= 1'b0;
			pend_hi   <= 1'b0;
			cnt_lo    <= '0;
			cnt_hi    <= '0;
		end else begin
			cmd_ready <= rnd[6];
			resp_0    <= '0;
			resp_1    <= '0;

			// Low half on port 0
			if (lo_due) begin
				resp_0  <= '{valid: 1'b1, cmd: cur, data: half_data(cur, 1'b0)};
				pend_lo <= 1'b0;
			end else if (inject_en && rnd[4]) begin
				resp_0 <= '{valid: 1'b1, cmd: foreign, data: half_data(foreign, 1'b0)};
			end
			if (pend_lo && !lo_due) begin
				cnt_lo <= cnt_lo - 3'd1;
			end

			// High half on port 1
			if (hi_due) begin
				resp_1  <= '{valid: 1'b1, cmd: cur, data: half_data(cur, 1'b1)};
				pend_hi <= 1'b0;
			end else if (inject_en && rnd[5]) begin
				resp_1 <= '{valid: 1'b1, cmd: foreign, data: half_data(foreign, 1'b1)};
			end
			if (pend_hi && !hi_due) begin
				cnt_hi <= cnt_hi - 3'd1;
			end

			// Independent delays put the halves in either order
			if (cmd_valid && cmd_ready) begin
				cur     <= cmd;
				pend_lo <= 1'b1;
				pend_hi <= 1'b1;
				cnt_lo  <= 3'd3 + 3'(rnd[1:0]);
				cnt_hi  <= 3'd3 + 3'(rnd[3:2]);
			end
		end
	end

endmodule

`default_nettype wire
